// File: sources.f
+incdir+common
common/gauss_pkg.sv
design/gauss_csr_apb.sv
requestor/gauss_line_counter.sv
requestor/gauss_requestor_fsm.sv
design/gauss_wr_fifo.sv
kernel/gauss_kernel.sv
design/gauss_accel_top.sv
verif/gauss_properties.sv
verif/gauss_tb.sv

// File: Bender.yml
package:
  name: gauss_blur

export_include_dirs:
  - common

sources:
  - files:
      - common/gauss_pkg.sv
      - design/gauss_csr_apb.sv
      - requestor/gauss_line_counter.sv
      - requestor/gauss_requestor_fsm.sv
      - design/gauss_wr_fifo.sv
      - kernel/gauss_kernel.sv
      - design/gauss_accel_top.sv
  - target: test
    files:
      - verif/gauss_properties.sv
      - verif/gauss_tb.sv

// File: verif/gauss_tb.sv
// Blur accelerator testbench with clock, APB tasks, memory model, reference function and checks
`timescale 1ns/1ps
`include "gauss_params.svh"

module gauss_tb;

  localparam logic [31:0] SRC_BASE  = 32'h0000_1000;
  localparam int          MAX_LINES = 32;
  localparam int          POLL_MAX  = 400;
  localparam int          APB_MAX   = 16;

  logic                     clk;
  logic                     rst_n;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [7:0]               paddr;
  logic [31:0]              pwdata;
  logic [31:0]              prdata;
  logic                     pready;
  logic                     pslverr;
  gauss_pkg::gauss_rd_req_t rd_req;
  logic                     rd_ready;
  logic                     rd_rsp_valid;
  gauss_pkg::gauss_line_t   rd_rsp_data;
  gauss_pkg::gauss_wr_req_t wr_req;
  logic                     wr_ready;

  // Source image and the pending read responses, oldest first
  gauss_pkg::gauss_line_t src_img [MAX_LINES];
  gauss_pkg::gauss_line_t rsp_data_q [$];
  int                     rsp_due_q [$];
  int                     cyc = 0;
  int                     last_due = 0;
  int                     rd_seen = 0;
  int                     wr_seen = 0;
  int                     exp_lines = 0;
  logic [31:0]            exp_dst = '0;
  int                     errors = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  gauss_accel_top uut (
    .clk(clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .rd_req(rd_req), .rd_ready(rd_ready), .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_data(rd_rsp_data), .wr_req(wr_req), .wr_ready(wr_ready)
  );

  bind gauss_accel_top gauss_properties u_props (
    .clk(clk), .rst_n(rst_n), .pready(pready), .rd_req(rd_req), .rd_ready(rd_ready),
    .wr_req(wr_req), .wr_ready(wr_ready), .fifo_fill(uu_fifo.fill),
    .in_flight(uu_counter.in_flight)
  );

  // Blur rule with edge pixels standing in for their missing neighbor
  function automatic gauss_pkg::gauss_line_t gauss_ref_line(input gauss_pkg::gauss_line_t line);
    gauss_pkg::gauss_line_t res;
    int left;
    int right;
    int sum;
    for (int i = 0; i < `GAUSS_LINE_PIX; i++) begin
      left  = (i == 0) ? line[0] : line[i-1];
      right = (i == `GAUSS_LINE_PIX - 1) ? line[i] : line[i+1];
      sum   = left + 2 * int'(line[i]) + right + 2;
      res[i] = 8'(sum / 4);
    end
    return res;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // One APB transfer, setup then access, sampled on the edge that completes it
  task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int n;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!pready && n < APB_MAX);
    if (!pready) begin
      $display("APB access to 0x%0h never completed", addr);
      errors++;
    end
    rdata = prdata;
    err   = pslverr;
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // Program one run, optionally poke start mid-run, then poll until done
  task automatic run_image(input int count, input logic [31:0] dst, input logic restart);
    logic [31:0] rdata;
    logic        err;
    int          n;
    exp_dst   = dst;
    exp_lines = count;
    wr_seen   = 0;
    rd_seen   = 0;
    apb_write(`GAUSS_REG_SRC, SRC_BASE, err);
    apb_write(`GAUSS_REG_DST, dst, err);
    apb_write(`GAUSS_REG_COUNT, count, err);
    apb_write(`GAUSS_REG_CTRL, 32'd1, err);
    apb_read(`GAUSS_REG_STATUS, rdata, err);
    if (count > 1) begin
      check("status.busy", rdata[0], 1'b1);
      check("status.done", rdata[1], 1'b0);
    end
    if (restart) begin
      apb_write(`GAUSS_REG_CTRL, 32'd1, err);
    end
    n = 0;
    while (n < POLL_MAX && rdata[1:0] != 2'b10) begin
      apb_read(`GAUSS_REG_STATUS, rdata, err);
      n++;
    end
    if (rdata[1:0] != 2'b10) begin
      $display("run of %0d lines not done after %0d status polls", count, POLL_MAX);
      errors++;
    end
    apb_read(`GAUSS_REG_DONE, rdata, err);
    check("lines_done", rdata, count);
    check("write count", wr_seen, count);
    check("read count", rd_seen, count);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  // Memory model with in-order reads of 1 to 4 cycles latency and random ready on both ports
  always @(posedge clk) begin : mem_model
    int idx;
    int due;
    cyc++;
    if (rst_n && rd_req.valid && rd_ready) begin
      // Lines are read in order from the source base
      check("rd_req.addr", rd_req.addr, SRC_BASE + 32'(rd_seen) * 8);
      rd_seen++;
      idx = int'((rd_req.addr - SRC_BASE) >> 3);
      if (rd_req.addr < SRC_BASE || idx >= MAX_LINES) begin
        $display("read request to 0x%0h falls outside the source image", rd_req.addr);
        errors++;
        rsp_data_q.push_back('0);
      end else begin
        rsp_data_q.push_back(src_img[idx]);
      end
      // Responses keep request order and leave at most one per cycle
      due = cyc + int'($urandom_range(4, 1)) - 1;
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_due_q.push_back(due);
    end
    #1;
    rd_rsp_valid = 1'b0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
      rd_rsp_valid = 1'b1;
      rd_rsp_data  = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end
    rd_ready = ($urandom % 4) != 0;
    wr_ready = ($urandom % 3) != 0;
  end

  // Every accepted write must be the next expected line at the next address
  always @(posedge clk) begin : write_compare
    gauss_pkg::gauss_line_t exp_line;
    if (rst_n && wr_req.valid && wr_ready) begin
      if (wr_seen >= exp_lines) begin
        $display("unexpected extra write to 0x%0h", wr_req.addr);
        errors++;
      end else begin
        exp_line = gauss_ref_line(src_img[wr_seen]);
        check("wr_req.addr", wr_req.addr, exp_dst + 32'(wr_seen) * 8);
        check("wr_req.line", wr_req.line, exp_line);
      end
      wr_seen++;
    end
  end

  initial begin : main
    logic [31:0] rdata;
    logic        err;
    int          mark;
    void'($urandom(32'h3adece91));
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    rd_ready     = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_data  = '0;
    wr_ready     = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset values, read back, 16-bit count and error responses
    mark = errors;
    for (int a = 0; a <= 'h14; a += 4) begin
      apb_read(8'(a), rdata, err);
      check("reset prdata", rdata, 32'd0);
      check("pslverr", err, 1'b0);
    end
    apb_write(`GAUSS_REG_SRC, 32'h1234_5678, err);
    check("pslverr", err, 1'b0);
    apb_write(`GAUSS_REG_DST, 32'hCAFE_0040, err);
    apb_write(`GAUSS_REG_COUNT, 32'h0003_0011, err);
    apb_read(`GAUSS_REG_SRC, rdata, err);
    check("src", rdata, 32'h1234_5678);
    apb_read(`GAUSS_REG_DST, rdata, err);
    check("dst", rdata, 32'hCAFE_0040);
    apb_read(`GAUSS_REG_COUNT, rdata, err);
    check("count", rdata, 32'h0000_0011);
    apb_read(8'h18, rdata, err);
    check("pslverr unmapped", err, 1'b1);
    apb_write(`GAUSS_REG_STATUS, 32'h3, err);
    check("pslverr status write", err, 1'b1);
    apb_write(`GAUSS_REG_DONE, 32'h5, err);
    check("pslverr done write", err, 1'b1);
    apb_read(`GAUSS_REG_STATUS, rdata, err);
    check("status", rdata, 32'd0);
    report_test("register access", mark);

    // Done is still clear from reset here so only the empty run can set it
    mark = errors;
    run_image(0, 32'h0000_B000, 1'b0);
    report_test("zero line count", mark);

    // Alternating extremes, with full and empty pixels at both edges
    mark = errors;
    src_img[0] = 64'h00FF_FF00_00FF_00FF;
    run_image(1, 32'h0000_8000, 1'b0);
    report_test("single line with extreme pixels", mark);

    mark = errors;
    for (int i = 0; i < 20; i++) begin
      src_img[i] = {$urandom, $urandom};
    end
    run_image(20, 32'h0000_9000, 1'b0);
    report_test("twenty lines under back-pressure with status", mark);

    mark = errors;
    run_image(20, 32'h0000_A000, 1'b1);
    report_test("start while busy is ignored", mark);

    if (uut.u_props.fail_count != 0) begin
      $display("%0d assertion failures in the bound properties", uut.u_props.fail_count);
      errors += uut.u_props.fail_count;
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : gauss_tb

// File: verif/gauss_properties.sv
// Bound assertions for APB ready, memory request stability, FIFO fill and in-flight limit
`timescale 1ns/1ps
`include "gauss_params.svh"

module gauss_properties (
  input logic                                         clk,
  input logic                                         rst_n,
  input logic                                         pready,
  input gauss_pkg::gauss_rd_req_t                     rd_req,
  input logic                                         rd_ready,
  input gauss_pkg::gauss_wr_req_t                     wr_req,
  input logic                                         wr_ready,
  input logic [$clog2(`GAUSS_FIFO_DEPTH + 1)-1:0]     fifo_fill,
  input logic [gauss_pkg::CNT_W-1:0]                  in_flight
);

  // Failure tally that the testbench folds into its verdict
  int fail_count = 0;

  // Zero wait states means pready never drops
  a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
    else begin
      $error("pready low on the APB port");
      fail_count++;
    end

  // A stalled read keeps its valid and address until the memory takes it
  a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_req.valid && !rd_ready) |=> (rd_req.valid && $stable(rd_req.addr)))
    else begin
      $error("read request changed while stalled");
      fail_count++;
    end

  // A stalled write keeps the whole request stable
  a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (wr_req.valid && !wr_ready) |=> (wr_req.valid && $stable(wr_req.addr) &&
                                       $stable(wr_req.line)))
    else begin
      $error("write request changed while stalled");
      fail_count++;
    end

  // The FIFO never holds more lines than it has slots
  a_fifo_fill: assert property (@(posedge clk) disable iff (!rst_n)
      fifo_fill <= `GAUSS_FIFO_DEPTH)
    else begin
      $error("write FIFO overflow");
      fail_count++;
    end

  // Reads stop once the in-flight window is full
  a_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
      in_flight <= `GAUSS_FIFO_DEPTH)
    else begin
      $error("lines in flight exceed the FIFO depth");
      fail_count++;
    end

endmodule : gauss_properties

// File: design/gauss_accel_top.sv
// Blur accelerator top level joining register block, requestor, counters, kernel and FIFO
`timescale 1ns/1ps
`include "gauss_params.svh"

module gauss_accel_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // APB host port
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [7:0]               paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  // Memory read port with in-order responses
  output gauss_pkg::gauss_rd_req_t rd_req,
  input  logic                     rd_ready,
  input  logic                     rd_rsp_valid,
  input  gauss_pkg::gauss_line_t   rd_rsp_data,
  // Memory write port
  output gauss_pkg::gauss_wr_req_t wr_req,
  input  logic                     wr_ready
);

  gauss_pkg::gauss_cfg_t           cfg;
  gauss_pkg::gauss_status_t        status;
  logic                            start;
  logic                            run_start;
  logic                            issue;
  logic                            wr_fire;
  logic                            issued_all;
  logic                            in_flight_full;
  logic                            all_written;
  logic [gauss_pkg::CNT_W-1:0]     issue_idx;
  logic [gauss_pkg::CNT_W-1:0]     write_idx;
  logic [gauss_pkg::CNT_W-1:0]     lines_done;
  logic [`GAUSS_ADDR_W-1:0]        wr_addr;
  logic                            busy;
  logic                            done;
  logic                            blur_valid;
  gauss_pkg::gauss_line_t          blur_line;
  logic                            head_valid;
  gauss_pkg::gauss_line_t          head_line;

  // Status gathers the FSM flags and the written line count
  assign status.busy       = busy;
  assign status.done       = done;
  assign status.lines_done = lines_done;

  // The FIFO head pairs with the address of the next line to write
  assign wr_req.valid = head_valid;
  assign wr_req.addr  = wr_addr;
  assign wr_req.line  = head_line;

  gauss_csr_apb uu_csr (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .status  (status),
    .cfg     (cfg),
    .start   (start)
  );

  gauss_requestor_fsm uu_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .cfg            (cfg),
    .rd_req         (rd_req),
    .rd_ready       (rd_ready),
    .wr_addr        (wr_addr),
    .issued_all     (issued_all),
    .in_flight_full (in_flight_full),
    .all_written    (all_written),
    .issue_idx      (issue_idx),
    .write_idx      (write_idx),
    .issue          (issue),
    .run_start      (run_start),
    .busy           (busy),
    .done           (done)
  );

  gauss_line_counter uu_counter (
    .clk            (clk),
    .rst_n          (rst_n),
    .run_start      (run_start),
    .issue          (issue),
    .wr_fire        (wr_fire),
    .line_count     (cfg.count),
    .issue_idx      (issue_idx),
    .write_idx      (write_idx),
    .lines_done     (lines_done),
    .issued_all     (issued_all),
    .in_flight_full (in_flight_full),
    .all_written    (all_written)
  );

  // Read responses feed the kernel directly since memory never stalls them
  gauss_kernel uu_kernel (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (rd_rsp_valid),
    .in_line   (rd_rsp_data),
    .out_valid (blur_valid),
    .out_line  (blur_line)
  );

  gauss_wr_fifo uu_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (blur_valid),
    .push_line  (blur_line),
    .wr_ready   (wr_ready),
    .wr_fire    (wr_fire),
    .head_valid (head_valid),
    .head_line  (head_line)
  );

endmodule : gauss_accel_top

// File: kernel/gauss_kernel.sv
// Two-stage pipelined [1 2 1]/4 blur of one image line with replicated edges
`timescale 1ns/1ps
`include "gauss_params.svh"

module gauss_kernel (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  gauss_pkg::gauss_line_t in_line,
  output logic                   out_valid,
  output gauss_pkg::gauss_line_t out_line
);

  localparam int unsigned PIX   = `GAUSS_LINE_PIX;
  localparam int unsigned PIX_W = `GAUSS_PIX_W;

  // Stage 1 holds the outer tap sum and the center pixel
  logic [PIX-1:0][PIX_W:0]   s1_side;
  gauss_pkg::gauss_line_t    s1_center;
  logic                      s1_valid;
  // Full weighted sum with the rounding term, two bits wider than a pixel
  logic [PIX-1:0][PIX_W+1:0] s2_sum;

  for (genvar i = 0; i < PIX; i++) begin : g_pix
    // Edge pixels stand in for their missing neighbor
    localparam int unsigned L = (i == 0) ? 0 : i - 1;
    localparam int unsigned R = (i == PIX - 1) ? i : i + 1;

    // Largest sum is 4 * 255 + 2 which still fits
    assign s2_sum[i] = s1_side[i] + {s1_center[i], 1'b0} + 2'd2;

    always_ff @(posedge clk) begin
      if (in_valid) begin
        s1_side[i]   <= in_line[L] + in_line[R];
        s1_center[i] <= in_line[i];
      end
      // Dropping two bits divides by four after rounding
      if (s1_valid) begin
        out_line[i] <= s2_sum[i][PIX_W+1:2];
      end
    end
  end

  // Valid bits follow the data one stage at a time
  // A new line may enter every cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

endmodule : gauss_kernel

// File: design/gauss_wr_fifo.sv
// Write FIFO buffering blurred lines until the memory accepts them
`timescale 1ns/1ps
`include "gauss_params.svh"

module gauss_wr_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push,
  input  gauss_pkg::gauss_line_t push_line,
  input  logic                   wr_ready,
  output logic                   wr_fire,
  output logic                   head_valid,
  output gauss_pkg::gauss_line_t head_line
);

  localparam int unsigned DEPTH = `GAUSS_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  gauss_pkg::gauss_line_t mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       fill;

  // The head shows up one cycle after the push that filled it
  assign head_valid = (fill != '0);
  assign head_line  = mem[rd_ptr];
  assign wr_fire    = head_valid && wr_ready;

  // Storage only ever moves forward with the write pointer
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_line;
    end
  end

  // Pointers wrap explicitly so any depth works
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (wr_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // The in-flight cap upstream keeps the fill at or under the depth
      fill <= fill + CNT_W'(push) - CNT_W'(wr_fire);
    end
  end

endmodule : gauss_wr_fifo

// File: requestor/gauss_requestor_fsm.sv
// Requestor FSM issuing line reads, forming write addresses and tracking busy and done
`timescale 1ns/1ps
`include "gauss_params.svh"

module gauss_requestor_fsm (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  gauss_pkg::gauss_cfg_t            cfg,
  output gauss_pkg::gauss_rd_req_t         rd_req,
  input  logic                             rd_ready,
  output logic [`GAUSS_ADDR_W-1:0]         wr_addr,
  input  logic                             issued_all,
  input  logic                             in_flight_full,
  input  logic                             all_written,
  input  logic [gauss_pkg::CNT_W-1:0]      issue_idx,
  input  logic [gauss_pkg::CNT_W-1:0]      write_idx,
  output logic                             issue,
  output logic                             run_start,
  output logic                             busy,
  output logic                             done
);

  localparam int unsigned ADDR_W     = `GAUSS_ADDR_W;
  localparam int unsigned LINE_BYTES = `GAUSS_LINE_PIX * `GAUSS_PIX_W / 8;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   done_q;

  // A start is only taken while idle
  // A start during a run has no effect
  assign run_start = start && (state == IDLE);

  // Request a line while reads remain and the in-flight window has room
  // The request stays stable under a low rd_ready since neither condition
  // can turn true without a transfer
  assign rd_req.valid = (state == ISSUE) && !in_flight_full && !issued_all;
  assign rd_req.addr  = cfg.src + ADDR_W'(issue_idx) * LINE_BYTES;
  assign issue        = rd_req.valid && rd_ready;

  // Writes leave in order so the FIFO head always belongs to write_idx
  assign wr_addr = cfg.dst + ADDR_W'(write_idx) * LINE_BYTES;

  assign busy = (state != IDLE);
  assign done = done_q;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        // An empty run finishes on the spot
        if (start && (cfg.count != '0)) begin
          state_nxt = ISSUE;
        end
      end
      ISSUE: begin
        if (issued_all) begin
          state_nxt = DRAIN;
        end
      end
      DRAIN: begin
        // all_written already counts a write accepted this cycle
        if (all_written) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= IDLE;
      done_q <= 1'b0;
    end else begin
      state <= state_nxt;
      // Start clears done except for a zero count which completes at once
      if (run_start) begin
        done_q <= (cfg.count == '0);
      end else if ((state == DRAIN) && all_written) begin
        done_q <= 1'b1;
      end
    end
  end

endmodule : gauss_requestor_fsm

// File: requestor/gauss_line_counter.sv
// Line counters for issued reads, accepted writes and lines in flight
`timescale 1ns/1ps
`include "gauss_params.svh"

module gauss_line_counter (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        run_start,
  input  logic                        issue,
  input  logic                        wr_fire,
  input  logic [gauss_pkg::CNT_W-1:0] line_count,
  output logic [gauss_pkg::CNT_W-1:0] issue_idx,
  output logic [gauss_pkg::CNT_W-1:0] write_idx,
  output logic [gauss_pkg::CNT_W-1:0] lines_done,
  output logic                        issued_all,
  output logic                        in_flight_full,
  output logic                        all_written
);

  localparam int unsigned CNT_W = gauss_pkg::CNT_W;

  logic [CNT_W-1:0] issued_cnt;
  logic [CNT_W-1:0] written_cnt;
  logic [CNT_W-1:0] in_flight;
  logic [CNT_W-1:0] issued_nxt;
  logic [CNT_W:0]   written_nxt;

  assign issued_nxt  = issued_cnt + issue;
  // One extra bit keeps the compare exact at the top of the range
  assign written_nxt = written_cnt + wr_fire;

  // Lines between read issue and write acceptance
  assign in_flight      = issued_cnt - written_cnt;
  assign in_flight_full = (in_flight >= CNT_W'(`GAUSS_FIFO_DEPTH));

  assign issued_all  = (issued_cnt == line_count);
  // Counting the current write lets the FSM finish on the accept cycle
  assign all_written = (written_nxt == {1'b0, line_count});

  assign issue_idx  = issued_cnt;
  assign write_idx  = written_cnt;
  assign lines_done = written_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n || run_start) begin
      issued_cnt  <= '0;
      written_cnt <= '0;
    end else begin
      issued_cnt  <= issued_nxt;
      written_cnt <= written_nxt[CNT_W-1:0];
    end
  end

endmodule : gauss_line_counter

// File: design/gauss_csr_apb.sv
// APB register block with configuration registers, start pulse and status readback
`timescale 1ns/1ps
`include "gauss_params.svh"

module gauss_csr_apb (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [7:0]               paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  input  gauss_pkg::gauss_status_t status,
  output gauss_pkg::gauss_cfg_t    cfg,
  output logic                     start
);

  logic access;
  logic wr_access;
  logic addr_mapped;
  logic addr_ro;

  // Zero wait states on every access
  assign pready = 1'b1;

  // The access phase is the second cycle of an APB transfer
  assign access    = psel && penable;
  assign wr_access = access && pwrite;

  // Decode the offset into read data and its access class
  always_comb begin
    addr_mapped = 1'b1;
    addr_ro     = 1'b0;
    prdata      = '0;
    case (paddr)
      // CTRL is write-only and reads back as zero
      `GAUSS_REG_CTRL: prdata = '0;
      `GAUSS_REG_STATUS: begin
        prdata  = {30'd0, status.done, status.busy};
        addr_ro = 1'b1;
      end
      `GAUSS_REG_SRC:   prdata = cfg.src;
      `GAUSS_REG_DST:   prdata = cfg.dst;
      `GAUSS_REG_COUNT: prdata = 32'(cfg.count);
      `GAUSS_REG_DONE: begin
        prdata  = 32'(status.lines_done);
        addr_ro = 1'b1;
      end
      default: addr_mapped = 1'b0;
    endcase
  end

  // Error on a hole in the map or on a write to a read-only register
  assign pslverr = access && (!addr_mapped || (pwrite && addr_ro));

  // Writes land at the access-phase edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg   <= '0;
      start <= 1'b0;
    end else begin
      // Start is a single-cycle pulse from bit 0 of CTRL
      start <= wr_access && (paddr == `GAUSS_REG_CTRL) && pwdata[0];
      if (wr_access) begin
        case (paddr)
          `GAUSS_REG_SRC:   cfg.src   <= pwdata;
          `GAUSS_REG_DST:   cfg.dst   <= pwdata;
          `GAUSS_REG_COUNT: cfg.count <= pwdata[gauss_pkg::CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

endmodule : gauss_csr_apb

// File: common/gauss_pkg.sv
// Blur accelerator shared types for lines, memory requests, configuration and status
`include "gauss_params.svh"

package gauss_pkg;

  // Width of line counts and line indices
  localparam int unsigned CNT_W = 16;

  // One image line as a packed pixel array
  // Pixel 0 sits in the low byte
  typedef logic [`GAUSS_LINE_PIX-1:0][`GAUSS_PIX_W-1:0] gauss_line_t;

  // Read request toward memory, one line per request
  typedef struct packed {
    logic                     valid;
    logic [`GAUSS_ADDR_W-1:0] addr;
  } gauss_rd_req_t;

  // Write request carrying one blurred line
  typedef struct packed {
    logic                     valid;
    logic [`GAUSS_ADDR_W-1:0] addr;
    gauss_line_t              line;
  } gauss_wr_req_t;

  // Run configuration as programmed by the host
  typedef struct packed {
    logic [`GAUSS_ADDR_W-1:0] src;
    logic [`GAUSS_ADDR_W-1:0] dst;
    logic [CNT_W-1:0]         count;
  } gauss_cfg_t;

  // Run status returned to the register block
  // Done stays set until the next accepted start
  typedef struct packed {
    logic             busy;
    logic             done;
    logic [CNT_W-1:0] lines_done;
  } gauss_status_t;

endpackage : gauss_pkg

// File: common/gauss_params.svh
// Blur accelerator sizing macros and APB register offsets
`ifndef GAUSS_PARAMS_SVH
`define GAUSS_PARAMS_SVH

// Each pixel is one byte and a line holds eight of them
`define GAUSS_PIX_W      8
`define GAUSS_LINE_PIX   8

// Write FIFO depth, which also caps the number of lines in flight
`define GAUSS_FIFO_DEPTH 4

// Byte address width on both memory ports
`define GAUSS_ADDR_W     32

// Register byte offsets on the APB port
`define GAUSS_REG_CTRL   8'h00
`define GAUSS_REG_STATUS 8'h04
`define GAUSS_REG_SRC    8'h08
`define GAUSS_REG_DST    8'h0C
`define GAUSS_REG_COUNT  8'h10
`define GAUSS_REG_DONE   8'h14

`endif
